/* common/u2_ctrl_defines.svh */
/* Settings-bus map, readback word indices and widths of the control core
   Addresses are 8-bit settings-bus register numbers, not byte addresses */
`ifndef U2_CTRL_DEFINES_SVH
`define U2_CTRL_DEFINES_SVH

// Settings bus widths
`define SET_ADDR_W 8
`define SET_DATA_W 32

// Control setting registers
`define SR_CLK       0
`define SR_SER       1
`define SR_ADC       2
`define SR_LED       3
`define SR_PHY       4
`define SR_LED_SRC   8
`define SR_IRQ_CLR   9
`define SR_IRQ_MASK  10
// Onetime timer here, periodic timer one above
`define SR_SIMTIMER  198

// Readback word indices
`define RB_PENDING   0
`define RB_MASK      1
`define RB_PRIO      2
`define RB_CYCLES    3
`define RB_ADDR_W    4

// Interrupt vector and LED widths
`define IRQ_W        16
`define LED_W        8

`endif

/* common/u2_ctrl_pkg.sv */
/* Types shared by the control core and its testbench
   Packed structs list their fields MSB first */
`include "u2_ctrl_defines.svh"

package u2_ctrl_pkg;

   // Settings bus words
   typedef logic [`SET_ADDR_W-1:0] set_addr_t;
   typedef logic [`SET_DATA_W-1:0] set_data_t;

   // Decoded write, one enable per setting register
   typedef struct packed {
      logic      clk;
      logic      ser;
      logic      adc;
      logic      led;
      logic      phy;
      logic      led_src;
      logic      irq_clr;
      logic      irq_mask;
      logic      onetime;
      logic      periodic;
      set_data_t data;
   } set_wr_t;

   // Level interrupt sources from outside the core
   typedef struct packed {
      logic buffer;
      logic spi;
      logic i2c;
      logic phy_int;
      logic underrun;
      logic overrun;
      logic pps;
      logic uart_rx;
      logic uart_tx;
      logic serdes_link_up;
      logic clk_status;
   } irq_src_t;

   typedef logic [`IRQ_W-1:0]     irq_vec_t;
   typedef logic [`LED_W-1:0]     led_t;
   typedef logic [`RB_ADDR_W-1:0] rb_addr_t;

   // Clock generator lines, data bits 4..0
   typedef struct packed {
      logic       clock_ready;
      logic [1:0] clk_en;
      logic [1:0] clk_sel;
   } clk_ctrl_t;

   // Serdes lines, data bits 3..0
   typedef struct packed {
      logic enable;
      logic prbsen;
      logic loopen;
      logic rx_en;
   } ser_ctrl_t;

   // ADC lines, data bits 3..0
   typedef struct packed {
      logic oe_a;
      logic on_a;
      logic oe_b;
      logic on_b;
   } adc_ctrl_t;

endpackage

/* hw/settings/settings_decode.sv */
/* Settings-bus decode, one cycle of latency, accepts a write every cycle
   Unmapped addresses give no enable at all */
`timescale 1ns/1ns
`include "u2_ctrl_defines.svh"

module settings_decode import u2_ctrl_pkg::*; (
   input  logic      dsp_clk,
   input  logic      wb_rst,
   input  logic      set_stb_i,
   input  set_addr_t set_addr_i,
   input  set_data_t set_data_i,
   output set_wr_t   set_wr_o
);

   set_wr_t    wr_nxt;
   set_wr_t    wr_q;
   logic [9:0] en_bits;

   // Address compare, all enables low without a strobe
   always_comb begin
      wr_nxt      = '0;
      wr_nxt.data = set_data_i;
      if (set_stb_i) begin
         wr_nxt.clk      = (set_addr_i == set_addr_t'(`SR_CLK));
         wr_nxt.ser      = (set_addr_i == set_addr_t'(`SR_SER));
         wr_nxt.adc      = (set_addr_i == set_addr_t'(`SR_ADC));
         wr_nxt.led      = (set_addr_i == set_addr_t'(`SR_LED));
         wr_nxt.phy      = (set_addr_i == set_addr_t'(`SR_PHY));
         wr_nxt.led_src  = (set_addr_i == set_addr_t'(`SR_LED_SRC));
         wr_nxt.irq_clr  = (set_addr_i == set_addr_t'(`SR_IRQ_CLR));
         wr_nxt.irq_mask = (set_addr_i == set_addr_t'(`SR_IRQ_MASK));
         // Timer pair
         wr_nxt.onetime  = (set_addr_i == set_addr_t'(`SR_SIMTIMER));
         wr_nxt.periodic = (set_addr_i == set_addr_t'(`SR_SIMTIMER + 1));
      end
   end

   // Pipeline stage toward the register blocks
   always_ff @(posedge dsp_clk) begin
      if (wb_rst) begin
         wr_q <= '0;
      end else begin
         wr_q <= wr_nxt;
      end
   end

   assign set_wr_o = wr_q;

   // Enables only, for the checks
   assign en_bits = {wr_q.clk, wr_q.ser, wr_q.adc, wr_q.led, wr_q.phy,
                     wr_q.led_src, wr_q.irq_clr, wr_q.irq_mask,
                     wr_q.onetime, wr_q.periodic};

   a_one_enable: assert property (@(posedge dsp_clk) disable iff (wb_rst)
      $onehot0(en_bits));

endmodule

/* hw/settings/control_regs.sv */
/* Clock-generator, serdes, ADC, PHY-reset and LED setting registers
   Outputs follow a write one cycle after the decoded enable */
`timescale 1ns/1ns
`include "u2_ctrl_defines.svh"

module control_regs import u2_ctrl_pkg::*; (
   input  logic      dsp_clk,
   input  logic      wb_rst,
   input  set_wr_t   set_wr_i,
   input  led_t      led_hw_i,
   output clk_ctrl_t clk_ctrl_o,
   output ser_ctrl_t ser_ctrl_o,
   output adc_ctrl_t adc_ctrl_o,
   output logic      phy_resetn_o,
   output led_t      leds_o
);

   clk_ctrl_t clk_q;
   ser_ctrl_t ser_q;
   adc_ctrl_t adc_q;
   led_t      led_sw_q;
   led_t      led_src_q;
   logic      phy_rst_q;

   // Clock generator, {clock_ready, clk_en, clk_sel}
   always_ff @(posedge dsp_clk) begin
      if (wb_rst) begin
         clk_q <= '0;
      end else if (set_wr_i.clk) begin
         clk_q <= clk_ctrl_t'(set_wr_i.data[4:0]);
      end
   end

   // Serdes and ADC enables share the low nibble layout
   always_ff @(posedge dsp_clk) begin
      if (wb_rst) begin
         ser_q <= '0;
         adc_q <= '0;
      end else begin
         if (set_wr_i.ser) begin
            ser_q <= ser_ctrl_t'(set_wr_i.data[3:0]);
         end
         if (set_wr_i.adc) begin
            adc_q <= adc_ctrl_t'(set_wr_i.data[3:0]);
         end
      end
   end

   // PHY reset, active high in the register
   always_ff @(posedge dsp_clk) begin
      if (wb_rst) begin
         phy_rst_q <= 1'b0;
      end else if (set_wr_i.phy) begin
         phy_rst_q <= set_wr_i.data[0];
      end
   end

   // LED software value and per-bit source select
   always_ff @(posedge dsp_clk) begin
      if (wb_rst) begin
         led_sw_q  <= '0;
         led_src_q <= '0;
      end else begin
         if (set_wr_i.led) begin
            led_sw_q <= set_wr_i.data[`LED_W-1:0];
         end
         if (set_wr_i.led_src) begin
            led_src_q <= set_wr_i.data[`LED_W-1:0];
         end
      end
   end

   assign clk_ctrl_o   = clk_q;
   assign ser_ctrl_o   = ser_q;
   assign adc_ctrl_o   = adc_q;
   // Pin is active low
   assign phy_resetn_o = ~phy_rst_q;

   // Src bit 1 takes hardware, 0 takes software
   assign leds_o = (led_src_q & led_hw_i) | (~led_src_q & led_sw_q);

endmodule

/* hw/timer/sim_timer.sv */
/* One-shot and periodic countdown timers on the settings bus
   Writing zero cancels or stops a timer, pulses are one cycle wide */
`timescale 1ns/1ns

module sim_timer import u2_ctrl_pkg::*; (
   input  logic    dsp_clk,
   input  logic    wb_rst,
   input  set_wr_t set_wr_i,
   output logic    onetime_o,
   output logic    periodic_o
);

   set_data_t ot_cnt;
   logic      ot_pulse;
   set_data_t per_len;
   set_data_t per_cnt;
   logic      per_pulse;

   //////////////////////////////////////////////////////////////////////
   // One-shot

   // Counts down from N, fires as it leaves 1
   always_ff @(posedge dsp_clk) begin
      if (wb_rst) begin
         ot_cnt   <= '0;
         ot_pulse <= 1'b0;
      end else if (set_wr_i.onetime) begin
         // A new write restarts or cancels
         ot_cnt   <= set_wr_i.data;
         ot_pulse <= 1'b0;
      end else if (ot_cnt != '0) begin
         ot_cnt   <= ot_cnt - 1'b1;
         ot_pulse <= (ot_cnt == set_data_t'(1));
      end else begin
         ot_pulse <= 1'b0;
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Periodic

   // Reload from per_len every P cycles, idle while per_len is zero
   always_ff @(posedge dsp_clk) begin
      if (wb_rst) begin
         per_len   <= '0;
         per_cnt   <= '0;
         per_pulse <= 1'b0;
      end else if (set_wr_i.periodic) begin
         per_len   <= set_wr_i.data;
         per_cnt   <= set_wr_i.data;
         per_pulse <= 1'b0;
      end else if (per_len != '0) begin
         if (per_cnt == set_data_t'(1)) begin
            per_cnt   <= per_len;
            per_pulse <= 1'b1;
         end else begin
            per_cnt   <= per_cnt - 1'b1;
            per_pulse <= 1'b0;
         end
      end else begin
         per_pulse <= 1'b0;
      end
   end

   assign onetime_o  = ot_pulse;
   assign periodic_o = per_pulse;

   // Pulses only from an armed timer that was not rewritten
   a_ot_armed: assert property (@(posedge dsp_clk) disable iff (wb_rst)
      onetime_o |-> $past((ot_cnt == set_data_t'(1)) && !set_wr_i.onetime));

   a_per_armed: assert property (@(posedge dsp_clk) disable iff (wb_rst)
      periodic_o |-> $past((per_len != '0) && !set_wr_i.periodic));

endmodule

/* hw/irq/irq_ctrl.sv */
/* Sticky pending bits with write-one-to-clear, mask and priority index
   A source still high at the clear sets its bit again */
`timescale 1ns/1ns
`include "u2_ctrl_defines.svh"

module irq_ctrl import u2_ctrl_pkg::*; (
   input  logic      dsp_clk,
   input  logic      wb_rst,
   input  set_wr_t   set_wr_i,
   input  irq_src_t  irq_src_i,
   input  logic      onetime_i,
   input  logic      periodic_i,
   output irq_vec_t  pending_o,
   output irq_vec_t  mask_o,
   output set_data_t prio_o,
   output logic      int_o
);

   irq_vec_t  irq_vec;
   irq_vec_t  clr_bits;
   irq_vec_t  pending_q;
   irq_vec_t  mask_q;
   irq_vec_t  masked;
   set_data_t prio;

   //////////////////////////////////////////////////////////////////////
   // Source vector, bit 0 is buffer and bit 12 periodic
   assign irq_vec = {3'b000, periodic_i, irq_src_i.clk_status,
                     irq_src_i.serdes_link_up, irq_src_i.uart_tx, irq_src_i.uart_rx,
                     irq_src_i.pps, irq_src_i.overrun, irq_src_i.underrun,
                     irq_src_i.phy_int, irq_src_i.i2c, irq_src_i.spi,
                     onetime_i, irq_src_i.buffer};

   assign clr_bits = set_wr_i.irq_clr ? set_wr_i.data[`IRQ_W-1:0] : '0;

   // Pending and mask
   always_ff @(posedge dsp_clk) begin
      if (wb_rst) begin
         pending_q <= '0;
         mask_q    <= '0;
      end else begin
         // Set wins over clear
         pending_q <= (pending_q & ~clr_bits) | irq_vec;
         if (set_wr_i.irq_mask) begin
            mask_q <= set_wr_i.data[`IRQ_W-1:0];
         end
      end
   end

   assign masked = pending_q & mask_q;

   // Highest masked pending bit, all ones when none
   always_comb begin
      prio = '1;
      for (int i = 0; i < `IRQ_W; i++) begin
         if (masked[i]) begin
            prio = set_data_t'(i);
         end
      end
   end

   assign pending_o = pending_q;
   assign mask_o    = mask_q;
   assign prio_o    = prio;
   assign int_o     = |masked;

   // An unmasked source reaches int_o on the next cycle
   a_src_to_int: assert property (@(posedge dsp_clk) disable iff (wb_rst)
      ((|(irq_vec & mask_q)) && !set_wr_i.irq_mask) |=> int_o);

   a_int_prio: assert property (@(posedge dsp_clk) disable iff (wb_rst)
      int_o == (prio_o != '1));

endmodule

/* hw/readback_mux.sv */
/* Readback port with one cycle latency, no stall
   Data reflects state in the strobe cycle, unlisted words read zero */
`timescale 1ns/1ns
`include "u2_ctrl_defines.svh"

module readback_mux import u2_ctrl_pkg::*; (
   input  logic      dsp_clk,
   input  logic      wb_rst,
   input  logic      rb_stb_i,
   input  rb_addr_t  rb_addr_i,
   input  irq_vec_t  pending_i,
   input  irq_vec_t  mask_i,
   input  set_data_t prio_i,
   output set_data_t rb_data_o,
   output logic      rb_ack_o
);

   set_data_t cyc_q;
   set_data_t rb_sel;
   set_data_t rb_data_q;
   logic      rb_ack_q;

   // Free-running cycle count since reset, wraps
   always_ff @(posedge dsp_clk) begin
      if (wb_rst) begin
         cyc_q <= '0;
      end else begin
         cyc_q <= cyc_q + 1'b1;
      end
   end

   // Word select
   always_comb begin
      case (rb_addr_i)
         rb_addr_t'(`RB_PENDING): rb_sel = set_data_t'(pending_i);
         rb_addr_t'(`RB_MASK):    rb_sel = set_data_t'(mask_i);
         rb_addr_t'(`RB_PRIO):    rb_sel = prio_i;
         rb_addr_t'(`RB_CYCLES):  rb_sel = cyc_q;
         default:                 rb_sel = '0;
      endcase
   end

   // Ack follows strobe by one cycle
   always_ff @(posedge dsp_clk) begin
      if (wb_rst) begin
         rb_ack_q <= 1'b0;
      end else begin
         rb_ack_q <= rb_stb_i;
      end
   end

   // Data only loads on a strobe
   always_ff @(posedge dsp_clk) begin
      if (rb_stb_i) begin
         rb_data_q <= rb_sel;
      end
   end

   assign rb_data_o = rb_data_q;
   assign rb_ack_o  = rb_ack_q;

endmodule

/* hw/u2_ctrl_core.sv */
/* Control plane of the motherboard core, single clock domain
   Settings writes take effect two cycles after the strobe */
`timescale 1ns/1ns

module u2_ctrl_core import u2_ctrl_pkg::*; (
   input  logic      dsp_clk,
   input  logic      wb_rst,
   // Settings bus
   input  logic      set_stb_i,
   input  set_addr_t set_addr_i,
   input  set_data_t set_data_i,
   // Readback
   input  logic      rb_stb_i,
   input  rb_addr_t  rb_addr_i,
   output set_data_t rb_data_o,
   output logic      rb_ack_o,
   // Interrupt sources, levels
   input  irq_src_t  irq_src_i,
   // Board control lines
   output clk_ctrl_t clk_ctrl_o,
   output ser_ctrl_t ser_ctrl_o,
   output adc_ctrl_t adc_ctrl_o,
   output logic      phy_resetn_o,
   output led_t      leds_o,
   output logic      int_o
);

   set_wr_t   set_wr;
   led_t      led_hw;
   logic      onetime_int;
   logic      periodic_int;
   irq_vec_t  pending;
   irq_vec_t  mask;
   set_data_t prio;

   //////////////////////////////////////////////////////////////////////
   // Decode
   settings_decode u_decode (
      .dsp_clk(dsp_clk), .wb_rst(wb_rst),
      .set_stb_i(set_stb_i), .set_addr_i(set_addr_i), .set_data_i(set_data_i),
      .set_wr_o(set_wr));

   //////////////////////////////////////////////////////////////////////
   // Execute

   // Hardware LEDs, clock status over link up
   assign led_hw = {6'b000000, irq_src_i.clk_status, irq_src_i.serdes_link_up};

   control_regs u_ctrl (
      .dsp_clk(dsp_clk), .wb_rst(wb_rst), .set_wr_i(set_wr), .led_hw_i(led_hw),
      .clk_ctrl_o(clk_ctrl_o), .ser_ctrl_o(ser_ctrl_o), .adc_ctrl_o(adc_ctrl_o),
      .phy_resetn_o(phy_resetn_o), .leds_o(leds_o));

   sim_timer u_timer (
      .dsp_clk(dsp_clk), .wb_rst(wb_rst), .set_wr_i(set_wr),
      .onetime_o(onetime_int), .periodic_o(periodic_int));

   irq_ctrl u_irq (
      .dsp_clk(dsp_clk), .wb_rst(wb_rst), .set_wr_i(set_wr), .irq_src_i(irq_src_i),
      .onetime_i(onetime_int), .periodic_i(periodic_int),
      .pending_o(pending), .mask_o(mask), .prio_o(prio), .int_o(int_o));

   //////////////////////////////////////////////////////////////////////
   // Result
   readback_mux u_rb (
      .dsp_clk(dsp_clk), .wb_rst(wb_rst), .rb_stb_i(rb_stb_i), .rb_addr_i(rb_addr_i),
      .pending_i(pending), .mask_i(mask), .prio_i(prio),
      .rb_data_o(rb_data_o), .rb_ack_o(rb_ack_o));

endmodule

/* sim/tb_u2_ctrl.sv */
/* Self-checking testbench for the control core, single clock, no stalls
   Control outputs are compared at each rising edge against a model delayed by the write latency */
`timescale 1ns/1ns
`include "u2_ctrl_defines.svh"

module tb_u2_ctrl import u2_ctrl_pkg::*; ();

   // Run length, longest timer count and period included
   localparam int N_WR       = 80;
   localparam int N_LED      = 12;
   localparam int LED_HOLD   = 6;
   localparam int TIMER_MAX  = 24;
   localparam int MAX_CYCLES = 2 * (20 + N_WR + N_LED * (LED_HOLD + 2) + 60
                                    + 3 * TIMER_MAX + 40);

   // Setting registers seen from outside
   typedef struct packed {
      clk_ctrl_t clk;
      ser_ctrl_t ser;
      adc_ctrl_t adc;
      led_t      led_sw;
      led_t      led_src;
      logic      phy;
   } regs_t;

   logic        dsp_clk;
   logic        wb_rst;
   logic        set_stb;
   set_addr_t   set_addr;
   set_data_t   set_data;
   logic        rb_stb;
   rb_addr_t    rb_addr;
   set_data_t   rb_data;
   logic        rb_ack;
   irq_src_t    irq_src;
   clk_ctrl_t   clk_ctrl;
   ser_ctrl_t   ser_ctrl;
   adc_ctrl_t   adc_ctrl;
   logic        phy_resetn;
   led_t        leds;
   logic        cpu_int;

   // Model state and write pipeline
   regs_t       model;
   logic        pipe_stb;
   set_addr_t   pipe_addr;
   set_data_t   pipe_data;
   logic [31:0] lfsr;
   int          mismatches;
   int          failures;
   int          cycles;

   u2_ctrl_core dut (
      .dsp_clk(dsp_clk), .wb_rst(wb_rst),
      .set_stb_i(set_stb), .set_addr_i(set_addr), .set_data_i(set_data),
      .rb_stb_i(rb_stb), .rb_addr_i(rb_addr), .rb_data_o(rb_data), .rb_ack_o(rb_ack),
      .irq_src_i(irq_src),
      .clk_ctrl_o(clk_ctrl), .ser_ctrl_o(ser_ctrl), .adc_ctrl_o(adc_ctrl),
      .phy_resetn_o(phy_resetn), .leds_o(leds), .int_o(cpu_int));

   // 4 ns clock
   initial dsp_clk = 1'b0;
   always #2 dsp_clk = ~dsp_clk;

   //////////////////////////////////////////////////////////////////////
   // Reference model

   // Fibonacci LFSR, taps 32 22 2 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   // One step per bit taken
   function automatic set_data_t rand_bits(input int n);
      set_data_t r;
      r = '0;
      for (int i = 0; i < n; i++) begin
         lfsr = lfsr_next(lfsr);
         r    = {r[30:0], lfsr[0]};
      end
      return r;
   endfunction

   // Register file after one write, unmapped addresses ignored
   function automatic regs_t apply_write(input regs_t r, input logic stb,
                                         input set_addr_t a, input set_data_t d);
      regs_t n;
      n = r;
      if (stb) begin
         case (a)
            set_addr_t'(`SR_CLK):     n.clk     = d[4:0];
            set_addr_t'(`SR_SER):     n.ser     = d[3:0];
            set_addr_t'(`SR_ADC):     n.adc     = d[3:0];
            set_addr_t'(`SR_LED):     n.led_sw  = d[7:0];
            set_addr_t'(`SR_LED_SRC): n.led_src = d[7:0];
            set_addr_t'(`SR_PHY):     n.phy     = d[0];
            default: ;
         endcase
      end
      return n;
   endfunction

   // Per bit, src 1 picks hardware (clk_status, link up in bits 1, 0)
   function automatic led_t led_mix(input led_t sw, input led_t src, input irq_src_t s);
      led_t hw;
      led_t o;
      hw = {6'b000000, s.clk_status, s.serdes_link_up};
      for (int i = 0; i < `LED_W; i++) begin
         o[i] = src[i] ? hw[i] : sw[i];
      end
      return o;
   endfunction

   // Interrupt vector bit order
   function automatic irq_vec_t irq_vector(input irq_src_t s, input logic ot, input logic per);
      irq_vec_t v;
      v     = '0;
      v[0]  = s.buffer;
      v[1]  = ot;
      v[2]  = s.spi;
      v[3]  = s.i2c;
      v[4]  = s.phy_int;
      v[5]  = s.underrun;
      v[6]  = s.overrun;
      v[7]  = s.pps;
      v[8]  = s.uart_rx;
      v[9]  = s.uart_tx;
      v[10] = s.serdes_link_up;
      v[11] = s.clk_status;
      v[12] = per;
      return v;
   endfunction

   // Index of the highest set bit, all ones for none
   function automatic set_data_t top_prio(input irq_vec_t m);
      set_data_t p;
      p = '1;
      for (int i = `IRQ_W - 1; i >= 0; i--) begin
         if (m[i] && p == '1) begin
            p = set_data_t'(i);
         end
      end
      return p;
   endfunction

   //////////////////////////////////////////////////////////////////////
   // Compare tasks

   task automatic check_clk(input string name, input clk_ctrl_t exp, input clk_ctrl_t act);
      if (exp !== act) begin
         mismatches++;
         $display("MISMATCH %s expected %h actual %h", name, exp, act);
      end
   endtask

   task automatic check_ser(input string name, input ser_ctrl_t exp, input ser_ctrl_t act);
      if (exp !== act) begin
         mismatches++;
         $display("MISMATCH %s expected %h actual %h", name, exp, act);
      end
   endtask

   task automatic check_adc(input string name, input adc_ctrl_t exp, input adc_ctrl_t act);
      if (exp !== act) begin
         mismatches++;
         $display("MISMATCH %s expected %h actual %h", name, exp, act);
      end
   endtask

   task automatic check_led(input string name, input led_t exp, input led_t act);
      if (exp !== act) begin
         mismatches++;
         $display("MISMATCH %s expected %h actual %h", name, exp, act);
      end
   endtask

   task automatic check_irq(input string name, input irq_vec_t exp, input irq_vec_t act);
      if (exp !== act) begin
         mismatches++;
         $display("MISMATCH %s expected %h actual %h", name, exp, act);
      end
   endtask

   task automatic check_data(input string name, input set_data_t exp, input set_data_t act);
      if (exp !== act) begin
         mismatches++;
         $display("MISMATCH %s expected %h actual %h", name, exp, act);
      end
   endtask

   task automatic check_bit(input string name, input logic exp, input logic act);
      if (exp !== act) begin
         mismatches++;
         $display("MISMATCH %s expected %b actual %b", name, exp, act);
      end
   endtask

   // Outputs stable since the last falling edge, model updates after the compare
   always @(posedge dsp_clk) begin
      if (wb_rst) begin
         model     <= '0;
         pipe_stb  <= 1'b0;
         pipe_addr <= '0;
         pipe_data <= '0;
      end else begin
         check_clk("clk_ctrl", model.clk, clk_ctrl);
         check_ser("ser_ctrl", model.ser, ser_ctrl);
         check_adc("adc_ctrl", model.adc, adc_ctrl);
         check_bit("phy_resetn", ~model.phy, phy_resetn);
         check_led("leds", led_mix(model.led_sw, model.led_src, irq_src), leds);
         // Decode stage, then register stage
         pipe_stb  <= set_stb;
         pipe_addr <= set_addr;
         pipe_data <= set_data;
         model     <= apply_write(model, pipe_stb, pipe_addr, pipe_data);
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Bus tasks, entered and left on a falling edge

   task automatic idle(input int n);
      repeat (n) @(negedge dsp_clk);
   endtask

   task automatic write_reg(input set_addr_t a, input set_data_t d);
      set_stb  = 1'b1;
      set_addr = a;
      set_data = d;
      @(negedge dsp_clk);
      set_stb  = 1'b0;
   endtask

   // Ack expected one cycle after the strobe
   task automatic read_word(input rb_addr_t a, output set_data_t d);
      int n;
      rb_stb  = 1'b1;
      rb_addr = a;
      @(negedge dsp_clk);
      rb_stb  = 1'b0;
      n = 0;
      while (!rb_ack && n < 8) begin
         @(negedge dsp_clk);
         n++;
      end
      if (!rb_ack) begin
         failures++;
         $display("Readback of word %0d got no ack", a);
      end
      d = rb_data;
   endtask

   //////////////////////////////////////////////////////////////////////
   // Stimulus

   initial begin : main
      set_data_t   rd;
      set_data_t   c0;
      set_data_t   c1;
      set_data_t   r;
      irq_vec_t    exp_pend;
      irq_vec_t    mask_now;
      irq_src_t    held;
      set_addr_t   a;
      int          n_ot;
      int          p_per;
      int          k;
      lfsr       = 32'h33b1_542e;
      mismatches = 0;
      failures   = 0;
      set_stb    = 1'b0;
      set_addr   = '0;
      set_data   = '0;
      rb_stb     = 1'b0;
      rb_addr    = '0;
      irq_src    = '0;
      wb_rst     = 1'b1;
      repeat (4) @(posedge dsp_clk);
      @(negedge dsp_clk);
      wb_rst = 1'b0;
      @(negedge dsp_clk);

      // Reset state
      check_clk("reset clk_ctrl", '0, clk_ctrl);
      check_ser("reset ser_ctrl", '0, ser_ctrl);
      check_adc("reset adc_ctrl", '0, adc_ctrl);
      check_led("reset leds", '0, leds);
      check_bit("reset phy_resetn", 1'b1, phy_resetn);
      check_bit("reset int_o", 1'b0, cpu_int);
      check_bit("reset rb_ack", 1'b0, rb_ack);
      read_word(rb_addr_t'(`RB_PENDING), rd);
      check_data("reset pending", '0, rd);
      read_word(rb_addr_t'(`RB_MASK), rd);
      check_data("reset mask", '0, rd);

      // Random writes, gaps about one in four, some unmapped
      for (int i = 0; i < N_WR; i++) begin
         r = rand_bits(3);
         case (r[2:0])
            3'd0: a = set_addr_t'(`SR_CLK);
            3'd1: a = set_addr_t'(`SR_SER);
            3'd2: a = set_addr_t'(`SR_ADC);
            3'd3: a = set_addr_t'(`SR_LED);
            3'd4: a = set_addr_t'(`SR_PHY);
            3'd5: a = set_addr_t'(`SR_LED_SRC);
            // 11 to 138, nothing mapped there
            default: a = set_addr_t'(11 + rand_bits(7));
         endcase
         set_stb  = (rand_bits(2) != '0);
         set_addr = a;
         set_data = rand_bits(32);
         @(negedge dsp_clk);
      end
      set_stb = 1'b0;
      idle(3);

      // LED mix with toggling hardware sources
      for (int i = 0; i < N_LED; i++) begin
         write_reg(set_addr_t'(`SR_LED), rand_bits(8));
         write_reg(set_addr_t'(`SR_LED_SRC), rand_bits(8));
         for (int j = 0; j < LED_HOLD; j++) begin
            r = rand_bits(2);
            irq_src.clk_status     = r[1];
            irq_src.serdes_link_up = r[0];
            @(negedge dsp_clk);
         end
      end
      irq_src = '0;

      //////////////////////////////////////////////////////////////////////
      // Interrupts
      write_reg(set_addr_t'(`SR_IRQ_CLR), 32'h0000_ffff);
      mask_now = irq_vec_t'(rand_bits(16));
      write_reg(set_addr_t'(`SR_IRQ_MASK), set_data_t'(mask_now));
      idle(2);
      exp_pend = '0;
      // Sparse one-cycle pulses
      for (int i = 0; i < 3; i++) begin
         r = rand_bits(11) & rand_bits(11);
         irq_src  = irq_src_t'(r[10:0]);
         exp_pend = exp_pend | irq_vector(irq_src, 1'b0, 1'b0);
         @(negedge dsp_clk);
         irq_src = '0;
         @(negedge dsp_clk);
      end
      read_word(rb_addr_t'(`RB_PENDING), rd);
      check_irq("pending after pulses", exp_pend, rd[15:0]);
      read_word(rb_addr_t'(`RB_MASK), rd);
      check_irq("mask readback", mask_now, rd[15:0]);
      read_word(rb_addr_t'(`RB_PRIO), rd);
      check_data("prio after pulses", top_prio(exp_pend & mask_now), rd);
      check_bit("int_o after pulses", |(exp_pend & mask_now), cpu_int);

      // Sources held high survive a clear
      r    = rand_bits(11) & rand_bits(11);
      held = irq_src_t'(r[10:0]);
      irq_src = held;
      @(negedge dsp_clk);
      write_reg(set_addr_t'(`SR_IRQ_CLR), 32'h0000_ffff);
      idle(1);
      exp_pend = irq_vector(held, 1'b0, 1'b0);
      read_word(rb_addr_t'(`RB_PENDING), rd);
      check_irq("pending after clear", exp_pend, rd[15:0]);
      read_word(rb_addr_t'(`RB_PRIO), rd);
      check_data("prio after clear", top_prio(exp_pend & mask_now), rd);
      check_bit("int_o after clear", |(exp_pend & mask_now), cpu_int);
      irq_src = '0;
      write_reg(set_addr_t'(`SR_IRQ_CLR), 32'h0000_ffff);
      idle(1);
      read_word(rb_addr_t'(`RB_PENDING), rd);
      check_irq("pending after release", '0, rd[15:0]);

      //////////////////////////////////////////////////////////////////////
      // One-shot timer, seen through int_o with only bit 1 unmasked
      write_reg(set_addr_t'(`SR_IRQ_MASK), 32'h0000_0002);
      idle(2);
      n_ot = 8 + int'(rand_bits(4));
      write_reg(set_addr_t'(`SR_SIMTIMER), set_data_t'(n_ot));
      k = 1;
      while (!cpu_int && k < n_ot + 4) begin
         @(negedge dsp_clk);
         k++;
      end
      if (!cpu_int) begin
         failures++;
         $display("One-shot timer of %0d cycles raised no interrupt by N+4", n_ot);
      end else if (k <= n_ot) begin
         failures++;
         $display("One-shot timer of %0d cycles fired early, after %0d", n_ot, k);
      end
      read_word(rb_addr_t'(`RB_PENDING), rd);
      check_irq("onetime pending", 16'h0002, rd[15:0]);
      write_reg(set_addr_t'(`SR_IRQ_CLR), 32'h0000_0002);

      // Periodic timer, bit 12 only
      write_reg(set_addr_t'(`SR_IRQ_MASK), 32'h0000_1000);
      p_per = 8 + int'(rand_bits(3));
      write_reg(set_addr_t'(`SR_SIMTIMER + 1), set_data_t'(p_per));
      k = 1;
      while (!cpu_int && k < p_per + 4) begin
         @(negedge dsp_clk);
         k++;
      end
      if (!cpu_int) begin
         failures++;
         $display("Periodic timer of %0d cycles never fired", p_per);
      end
      write_reg(set_addr_t'(`SR_IRQ_CLR), 32'h0000_1000);
      @(negedge dsp_clk);
      k = 2;
      if (cpu_int) begin
         failures++;
         $display("Clearing bit 12 did not drop the interrupt");
      end
      while (!cpu_int && k < p_per + 4) begin
         @(negedge dsp_clk);
         k++;
      end
      if (!cpu_int) begin
         failures++;
         $display("Periodic timer of %0d cycles did not fire again by P+4", p_per);
      end
      // Stop and clean up
      write_reg(set_addr_t'(`SR_SIMTIMER + 1), '0);
      write_reg(set_addr_t'(`SR_IRQ_CLR), 32'h0000_ffff);
      write_reg(set_addr_t'(`SR_IRQ_MASK), '0);
      idle(2);

      // Cycle counter, strobes k cycles apart
      k = 5 + int'(rand_bits(4));
      read_word(rb_addr_t'(`RB_CYCLES), c0);
      idle(k - 1);
      read_word(rb_addr_t'(`RB_CYCLES), c1);
      check_data("cycle counter delta", set_data_t'(k), c1 - c0);
      read_word(rb_addr_t'(7), rd);
      check_data("unlisted readback word", '0, rd);

      // Ack lasts a single cycle
      idle(1);
      check_bit("rb_ack after one cycle", 1'b0, rb_ack);
      idle(1);
      $display("Errors: %0d mismatches, %0d other failures", mismatches, failures);
      if (mismatches == 0 && failures == 0) begin
         $display("Everything OK");
      end else begin
         $display("Something failed");
      end
      $finish;
   end

   // Watchdog
   initial begin : watchdog
      cycles = 0;
      while (cycles < MAX_CYCLES) begin
         @(posedge dsp_clk);
         cycles++;
      end
      failures++;
      $display("Timeout after %0d cycles, the tests did not finish", cycles);
      $display("Errors: %0d mismatches, %0d other failures", mismatches, failures);
      $display("Something failed");
      $finish;
   end

endmodule

/* src.f */
+incdir+common
common/u2_ctrl_pkg.sv
hw/settings/settings_decode.sv
hw/settings/control_regs.sv
hw/timer/sim_timer.sv
hw/irq/irq_ctrl.sv
hw/readback_mux.sv
hw/u2_ctrl_core.sv
sim/tb_u2_ctrl.sv

/* Makefile */
# Verilator build and run of the control core testbench

VERILATOR ?= verilator
TOP       ?= tb_u2_ctrl
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SRCS := $(filter-out +%,$(shell cat $(FILELIST)))
SRCS += $(wildcard common/*.svh)
SIM  := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run, pass only if the pass message appears"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

test: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "Everything OK"

clean:
	rm -rf $(BUILD_DIR)
